/* dv/program_stimulus.hex */
// Words 0x00..0x43 program image, four instruction words per line
// From 0x50 expected stores: address mask data, a zero record ends the list
@00
24010005 2402fffd 00221821 ac030100
00222023 ac040104 3c051234 34a5abcd
00023043 ac050108 ac06010c 0041382a
0041402b 00e84827 ac090110 00015100
00055a02 014b6026 ac0c0114 a0050121
a0050123 a4050122 a4050124 a0050120
a0050122 800d0123 900e0123 840f0122
94100122 8c110120 ac0d0130 ac0e0134
ac0f0138 ac10013c ac110140 1022001e
24120011 ac120150 14220002 24130022
24130099 ac130154 18400002 24140033
24140098 1c400014 ac140158 0c00003c
24150044 ac150160 08000035 24160055
24160097 ac160164 24170100 02e0c009
ac180168 ac0101f0 1000ffff 00000000
ac1f015c 03e00008 ac010170 00000000
03000008 ac020174 ac0001f8 1000ffff
@50
00000100 0000000f 00000002
00000104 0000000f 00000008
00000108 0000000f 1234abcd
0000010c 0000000f fffffffe
00000110 0000000f fffffffe
00000114 0000000f 001234fb
00000121 00000002 cdcdcdcd
00000123 00000008 cdcdcdcd
00000122 0000000c abcdabcd
00000124 00000003 abcdabcd
00000120 00000001 cdcdcdcd
00000122 00000004 cdcdcdcd
00000130 0000000f ffffffab
00000134 0000000f 000000ab
00000138 0000000f ffffabcd
0000013c 0000000f 0000abcd
00000140 0000000f abcdcdcd
00000150 0000000f 00000011
00000154 0000000f 00000022
00000158 0000000f 00000033
0000015c 0000000f 000000c4
00000170 0000000f 00000005
00000160 0000000f 00000044
00000164 0000000f 00000055
00000168 0000000f 000000e4
00000174 0000000f fffffffd
000001f0 0000000f 00000005
00000000 00000000 00000000

/* sim.f */
+incdir+common
common/mipsIsaPkg.sv
common/mipsPipePkg.sv
hdl/instrDecoder.sv
hdl/regFile.sv
hdl/alu.sv
hdl/branchUnit.sv
hdl/memAlign.sv
mipsCore/mipsCore.sv
dv/mipsCore_sva.sv
dv/tb_mipsCore.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_mipsCore -f sim.f -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
  exit 0
fi
exit 1

/* dv/tb_mipsCore.sv */
`timescale 1ns/10ps
`include "mips_cfg.svh"

module tb_mipsCore;

  localparam int RecBase = 80;
  localparam int StimWords = 256;
  localparam int RamWords = 256;
  localparam int MaxRecs = 40;
  localparam int Timeout = 4000;
  localparam int DrainCycles = 20;

  logic        clk;
  logic        rst;
  logic        stall;
  logic [31:0] imemAddr;
  logic        imemRe;
  logic [31:0] instr;
  logic [31:0] dmemAddr;
  logic        dmemRe;
  logic [3:0]  dmemWe;
  logic [31:0] dmemDin;
  logic [31:0] dmemDout;

  logic [31:0] stim [0:StimWords-1];
  logic [31:0] ram [0:RamWords-1];
  logic [7:0]  romIdx;
  logic [7:0]  ramIdx;
  logic [31:0] lfsr;
  logic        stallEn;
  logic        bitA;
  logic        bitB;
  int          mismatches;
  int          otherFails;
  int          assertFails;
  int          recIdx;
  int          numRecs;
  int          cycles;

  mipsCore i_dut (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .imemAddr(imemAddr),
    .imemRe  (imemRe),
    .instr   (instr),
    .dmemAddr(dmemAddr),
    .dmemRe  (dmemRe),
    .dmemWe  (dmemWe),
    .dmemDin (dmemDin),
    .dmemDout(dmemDout)
  );

  bind mipsCore mipsCore_sva i_sva (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .imemRe  (imemRe),
    .dmemRe  (dmemRe),
    .dmemWe  (dmemWe),
    .dmemAddr(dmemAddr)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One field of an expected store record (0 address, 1 mask, 2 data)
  function automatic logic [31:0] recWord(input int n, input int k);
    logic [7:0] idx;
    idx = 8'(RecBase + 3 * n + k);
    return stim[idx];
  endfunction

  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // **************************************************
  // Memory models
  // **************************************************

  assign romIdx = imemAddr[9:2];
  assign ramIdx = dmemAddr[9:2];

  always @(posedge clk) begin
    if (imemRe) begin
      instr <= (romIdx < 8'd80) ? stim[romIdx] : 32'd0;
    end
  end

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmemWe[b]) ram[ramIdx][8*b +: 8] <= dmemDin[8*b +: 8];
    end
    if (dmemRe) dmemDout <= ram[ramIdx];
  end

  // Every store is compared with the next expected record
  always @(posedge clk) begin
    if (!rst && dmemWe != 4'b0000) begin
      if (recIdx >= numRecs) begin
        $display("Unexpected store to address %h after the last expected record", dmemAddr);
        otherFails++;
      end else begin
        checkValue(dmemAddr, recWord(recIdx, 0), "store address");
        checkValue({28'd0, dmemWe}, recWord(recIdx, 1), "store mask");
        checkValue(dmemDin, recWord(recIdx, 2), "store data");
        recIdx++;
      end
    end
  end

  // Stall on about one cycle in four, two LFSR bits per cycle
  always @(negedge clk) begin
    if (stallEn) begin
      lfsr = lfsrStep(lfsr);
      bitA = lfsr[0];
      lfsr = lfsrStep(lfsr);
      bitB = lfsr[0];
      stall <= bitA & bitB;
    end else begin
      stall <= 1'b0;
    end
  end

  // **************************************************
  // Main sequence
  // **************************************************

  initial begin
    rst = 1'b1;
    stall = 1'b0;
    stallEn = 1'b0;
    instr = 32'd0;
    dmemDout = 32'd0;
    lfsr = 32'd32;
    mismatches = 0;
    otherFails = 0;
    assertFails = 0;
    recIdx = 0;
    numRecs = 0;
    for (int i = 0; i < RamWords; i++) begin
      ram[i] = 32'hdead0000 ^ (i * 32'h00010003);
    end
    $readmemh("dv/program_stimulus.hex", stim);
    while (numRecs < MaxRecs && recWord(numRecs, 1) != 32'd0) begin
      numRecs++;
    end

    repeat (10) @(posedge clk);
    stallEn = 1'b1;
    @(negedge clk);
    rst = 1'b0;
    checkValue(imemAddr, `MIPS_RESET_PC, "first fetch address");

    cycles = 0;
    while (recIdx < numRecs && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (recIdx < numRecs) begin
      $display("Timeout: only %0d of %0d expected stores arrived", recIdx, numRecs);
      otherFails++;
    end

    // Give a stray store from a wrong path the chance to show up
    cycles = 0;
    while (cycles < DrainCycles) begin
      @(negedge clk);
      cycles++;
    end

    assertFails = i_dut.i_sva.failCount;
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, otherFails, assertFails);
    if (mismatches == 0 && otherFails == 0 && assertFails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* dv/mipsCore_sva.sv */
`timescale 1ns/10ps

module mipsCore_sva (
  input logic        clk,
  input logic        rst,
  input logic        stall,
  input logic        imemRe,
  input logic        dmemRe,
  input logic [3:0]  dmemWe,
  input logic [31:0] dmemAddr
);

  int failCount;

  initial failCount = 0;

  // Memory strobes are gated off while frozen
  assert property (@(posedge clk) stall |-> (dmemWe == 4'b0000 && !dmemRe && !imemRe))
    else begin
      failCount++;
      $error("Memory strobe active while stall is high");
    end

  // The cycle after a reset cycle carries no data strobe
  assert property (@(posedge clk) $past(rst) |-> (dmemWe == 4'b0000 && !dmemRe))
    else begin
      failCount++;
      $error("Data strobe active right after reset");
    end

  assert property (@(posedge clk) (stall && $past(stall)) |-> $stable(dmemAddr))
    else begin
      failCount++;
      $error("Data address moved during a stall");
    end

endmodule

/* mipsCore/mipsCore.sv */
`timescale 1ns/10ps
`include "mips_cfg.svh"

module mipsCore import mipsIsaPkg::*, mipsPipePkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        stall,
  output logic [31:0] imemAddr,
  output logic        imemRe,
  input  logic [31:0] instr,
  output logic [31:0] dmemAddr,
  output logic        dmemRe,
  output logic [3:0]  dmemWe,
  output logic [31:0] dmemDin,
  input  logic [31:0] dmemDout
);

  typedef struct packed {
    instrWord_u  instr;
    logic [31:0] pc;
    logic [31:0] imm;
    decCtrl_s    ctrl;
  } deReg_s;

  typedef struct packed {
    wbCtrl_s     wb;
    logic [31:0] aluOut;
  } emReg_s;

  instrWord_u  instrD;
  decCtrl_s    ctrlD;
  logic [31:0] immD;
  logic [31:0] pcD;
  logic        validD;
  logic [31:0] nextPc;
  deReg_s      deReg;
  emReg_s      emReg;
  logic [31:0] rfA;
  logic [31:0] rfB;
  logic [31:0] regA;
  logic [31:0] regB;
  logic [31:0] aluA;
  logic [31:0] aluB;
  logic [31:0] aluRes;
  logic [31:0] aluOutE;
  logic [4:0]  linkReg;
  logic [4:0]  writeRegE;
  logic        isLink;
  logic        fwdOk;
  wbCtrl_s     wbE;
  logic [31:0] resultM;

  // **************************************************
  // Fetch and decode
  // **************************************************

  assign instrD = instr;

  // A stall re-presents the word already in D
  assign imemAddr = (stall ? pcD : nextPc) & `MIPS_PHYS_MASK;
  assign imemRe = ~stall;

  // pcD starts one word early, the first fetched word is dropped and fetched again
  always_ff @(posedge clk) begin
    if (rst) begin
      pcD <= `MIPS_RESET_PC - 32'd4;
      validD <= 1'b0;
    end else if (!stall) begin
      pcD <= nextPc;
      validD <= 1'b1;
    end
  end

  instrDecoder i_decoder (
    .instr(instrD),
    .ctrl (ctrlD)
  );

  assign immD = ctrlD.zeroExt ? {16'd0, instrD.i.imm} : {{16{instrD.i.imm[15]}}, instrD.i.imm};

  always_ff @(posedge clk) begin
    if (rst) begin
      deReg <= '0;
    end else if (!stall) begin
      deReg <= validD ? deReg_s'{instr: instrD, pc: pcD, imm: immD, ctrl: ctrlD} : '0;
    end
  end

  // **************************************************
  // Execute
  // **************************************************

  regFile i_regFile (
    .clk   (clk),
    .we    (emReg.wb.regWrite & ~stall),
    .raddrA(deReg.instr.r.rs),
    .raddrB(deReg.instr.r.rt),
    .waddr (emReg.wb.writeReg),
    .wdata (resultM),
    .rdataA(rfA),
    .rdataB(rfB)
  );

  // Loads are never forwarded, software keeps the load delay slot
  assign fwdOk = emReg.wb.regWrite & ~emReg.wb.memRead & (emReg.wb.writeReg != 5'd0);
  assign regA = (fwdOk && emReg.wb.writeReg == deReg.instr.r.rs) ? emReg.aluOut : rfA;
  assign regB = (fwdOk && emReg.wb.writeReg == deReg.instr.r.rt) ? emReg.aluOut : rfB;

  assign aluA = deReg.ctrl.shiftImm ? {27'd0, deReg.instr.r.shamt} : regA;
  assign aluB = deReg.ctrl.aluSrcImm ? deReg.imm : regB;

  alu i_alu (
    .a     (aluA),
    .b     (aluB),
    .op    (deReg.ctrl.aluOp),
    .result(aluRes)
  );

  branchUnit i_branch (
    .kind   (deReg.ctrl.branchKind),
    .instrE (deReg.instr),
    .pcE    (deReg.pc),
    .pcD    (pcD),
    .regA   (regA),
    .regB   (regB),
    .nextPc (nextPc),
    .linkReg(linkReg)
  );

  // Link writes the address after the delay slot
  assign isLink = deReg.ctrl.branchKind inside {BR_JAL, BR_JALR};
  assign aluOutE = isLink ? deReg.pc + 32'd8 : aluRes;
  assign writeRegE = isLink ? linkReg
                   : (deReg.ctrl.regDst ? deReg.instr.r.rd : deReg.instr.r.rt);

  memAlign i_memAlign (
    .addrE    (aluRes),
    .storeData(regB),
    .sizeE    (deReg.ctrl.memSize),
    .storeEn  (deReg.ctrl.memWrite & ~stall),
    .byteMask (dmemWe),
    .laneData (dmemDin),
    .wbCtrl   (emReg.wb),
    .aluOutM  (emReg.aluOut),
    .memData  (dmemDout),
    .result   (resultM)
  );

  // Hold the M address while stalled so the read data stays put
  assign dmemAddr = (stall ? emReg.aluOut : aluRes) & `MIPS_PHYS_MASK;
  assign dmemRe = deReg.ctrl.memRead & ~stall;

  // **************************************************
  // Write
  // **************************************************

  assign wbE = '{
    regWrite:     deReg.ctrl.regWrite,
    memRead:      deReg.ctrl.memRead,
    loadUnsigned: deReg.ctrl.loadUnsigned,
    memSize:      deReg.ctrl.memSize,
    writeReg:     writeRegE
  };

  always_ff @(posedge clk) begin
    if (rst) begin
      emReg <= '0;
    end else if (!stall) begin
      emReg <= emReg_s'{wb: wbE, aluOut: aluOutE};
    end
  end

endmodule

/* hdl/memAlign.sv */
`timescale 1ns/10ps

module memAlign import mipsPipePkg::*; (
  input  logic [31:0] addrE,
  input  logic [31:0] storeData,
  input  memSize_e    sizeE,
  input  logic        storeEn,
  output logic [3:0]  byteMask,
  output logic [31:0] laneData,
  input  wbCtrl_s     wbCtrl,
  input  logic [31:0] aluOutM,
  input  logic [31:0] memData,
  output logic [31:0] result
);

  logic [31:0] loadShifted;
  logic        signByte;
  logic        signHalf;

  // **************************************************
  // Store lanes, byte 0 sits in bits 7:0
  // **************************************************

  always_comb begin
    byteMask = 4'b0000;
    laneData = storeData;
    case (sizeE)
      MEM_BYTE: begin
        laneData = {4{storeData[7:0]}};
        if (storeEn) byteMask = 4'b0001 << addrE[1:0];
      end
      MEM_HALF: begin
        laneData = {2{storeData[15:0]}};
        if (storeEn) byteMask = addrE[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        if (storeEn) byteMask = 4'b1111;
      end
    endcase
  end

  // **************************************************
  // Load extraction and extension
  // **************************************************

  // Bring the addressed lane down to bit 0
  assign loadShifted = memData >> {aluOutM[1:0], 3'b000};
  assign signByte = ~wbCtrl.loadUnsigned & loadShifted[7];
  assign signHalf = ~wbCtrl.loadUnsigned & loadShifted[15];

  always_comb begin
    if (!wbCtrl.memRead) begin
      result = aluOutM;
    end else begin
      case (wbCtrl.memSize)
        MEM_BYTE: result = {{24{signByte}}, loadShifted[7:0]};
        MEM_HALF: result = {{16{signHalf}}, loadShifted[15:0]};
        default:  result = memData;
      endcase
    end
  end

endmodule

/* hdl/branchUnit.sv */
`timescale 1ns/10ps

module branchUnit import mipsIsaPkg::*, mipsPipePkg::*; (
  input  branchKind_e kind,
  input  instrWord_u  instrE,
  input  logic [31:0] pcE,
  input  logic [31:0] pcD,
  input  logic [31:0] regA,
  input  logic [31:0] regB,
  output logic [31:0] nextPc,
  output logic [4:0]  linkReg
);

  logic [31:0] slotPc;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic        taken;

  // Targets are relative to the delay slot
  assign slotPc = pcE + 32'd4;
  assign branchTarget = slotPc + {{14{instrE.i.imm[15]}}, instrE.i.imm, 2'b00};
  assign jumpTarget = {slotPc[31:28], instrE.i.rs, instrE.i.rt, instrE.i.imm, 2'b00};

  always_comb begin
    case (kind)
      BR_BEQ:  taken = (regA == regB);
      BR_BNE:  taken = (regA != regB);
      BR_BLEZ: taken = ($signed(regA) <= 32'sd0);
      BR_BGTZ: taken = ($signed(regA) > 32'sd0);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (kind)
      BR_J, BR_JAL:   nextPc = jumpTarget;
      BR_JR, BR_JALR: nextPc = regA;
      default:        nextPc = taken ? branchTarget : pcD + 32'd4;
    endcase
  end

  assign linkReg = (kind == BR_JAL) ? 5'd31 : instrE.r.rd;

endmodule

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu import mipsIsaPkg::*; (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  aluOp_e      op,
  output logic [31:0] result
);

  logic [4:0] shamt;

  assign shamt = a[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_NOR:  result = ~(a | b);
      ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'd0, a < b};
      // Shifts move b by the amount in a
      ALU_SLL:  result = b << shamt;
      ALU_SRL:  result = b >> shamt;
      ALU_SRA:  result = $unsigned($signed(b) >>> shamt);
      ALU_LUI:  result = {b[15:0], 16'd0};
      default:  result = 32'd0;
    endcase
  end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/10ps
`include "mips_cfg.svh"

module regFile (
  input  logic        clk,
  input  logic        we,
  input  logic [4:0]  raddrA,
  input  logic [4:0]  raddrB,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  output logic [31:0] rdataA,
  output logic [31:0] rdataB
);

  logic [31:0] regs [`MIPS_NUM_REGS];

  always_ff @(posedge clk) begin
    if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // Register zero is never written, so force its read value
  assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
  assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

endmodule

/* hdl/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder import mipsIsaPkg::*, mipsPipePkg::*; (
  input  instrWord_u instr,
  output decCtrl_s   ctrl
);

  always_comb begin
    ctrl = '0;
    case (instr.i.opcode)
      OP_RTYPE: begin
        ctrl.regDst = 1'b1;
        ctrl.regWrite = 1'b1;
        case (instr.r.funct)
          FN_ADDU: ctrl.aluOp = ALU_ADD;
          FN_SUBU: ctrl.aluOp = ALU_SUB;
          FN_AND:  ctrl.aluOp = ALU_AND;
          FN_OR:   ctrl.aluOp = ALU_OR;
          FN_XOR:  ctrl.aluOp = ALU_XOR;
          FN_NOR:  ctrl.aluOp = ALU_NOR;
          FN_SLT:  ctrl.aluOp = ALU_SLT;
          FN_SLTU: ctrl.aluOp = ALU_SLTU;
          FN_SLL:  ctrl.aluOp = ALU_SLL;
          FN_SRL:  ctrl.aluOp = ALU_SRL;
          FN_SRA:  ctrl.aluOp = ALU_SRA;
          FN_JR: begin
            ctrl.branchKind = BR_JR;
            ctrl.regWrite = 1'b0;
          end
          FN_JALR: ctrl.branchKind = BR_JALR;
          default: ctrl = '0;
        endcase
        // Shift amount comes from the shamt field
        ctrl.shiftImm = ctrl.aluOp inside {ALU_SLL, ALU_SRL, ALU_SRA};
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.zeroExt = instr.i.opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        case (instr.i.opcode)
          OP_SLTI:  ctrl.aluOp = ALU_SLT;
          OP_SLTIU: ctrl.aluOp = ALU_SLTU;
          OP_ANDI:  ctrl.aluOp = ALU_AND;
          OP_ORI:   ctrl.aluOp = ALU_OR;
          OP_XORI:  ctrl.aluOp = ALU_XOR;
          OP_LUI:   ctrl.aluOp = ALU_LUI;
          default:  ctrl.aluOp = ALU_ADD;
        endcase
      end
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead = 1'b1;
        ctrl.loadUnsigned = instr.i.opcode[2];
        ctrl.memSize = memSize_e'(instr.i.opcode[1:0]);
      end
      OP_SB, OP_SH, OP_SW: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.memSize = memSize_e'(instr.i.opcode[1:0]);
      end
      OP_BEQ:  ctrl.branchKind = BR_BEQ;
      OP_BNE:  ctrl.branchKind = BR_BNE;
      OP_BLEZ: ctrl.branchKind = BR_BLEZ;
      OP_BGTZ: ctrl.branchKind = BR_BGTZ;
      OP_J:    ctrl.branchKind = BR_J;
      OP_JAL: begin
        ctrl.branchKind = BR_JAL;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

/* common/mipsPipePkg.sv */
package mipsPipePkg;

  import mipsIsaPkg::*;

  // Same encoding as the low two opcode bits of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd3
  } memSize_e;

  // Branch and jump kinds resolved in E
  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ, BR_BGTZ, BR_J, BR_JAL, BR_JR, BR_JALR
  } branchKind_e;

  // Decode control, all zero is a no-op
  typedef struct packed {
    aluOp_e      aluOp;
    logic        aluSrcImm;
    logic        shiftImm;
    logic        regDst;
    logic        regWrite;
    logic        memWrite;
    logic        memRead;
    logic        loadUnsigned;
    memSize_e    memSize;
    logic        zeroExt;
    branchKind_e branchKind;
  } decCtrl_s;

  // Write stage control
  typedef struct packed {
    logic       regWrite;
    logic       memRead;
    logic       loadUnsigned;
    memSize_e   memSize;
    logic [4:0] writeReg;
  } wbCtrl_s;

endpackage

/* common/mipsIsaPkg.sv */
package mipsIsaPkg;

  // Register-format field layout
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rType_s;

  // Immediate-format field layout, low 26 bits double as the jump target
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } iType_s;

  typedef union packed {
    rType_s r;
    iType_s i;
  } instrWord_u;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00, OP_J     = 6'h02, OP_JAL   = 6'h03, OP_BEQ  = 6'h04,
    OP_BNE   = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07, OP_ADDIU = 6'h09,
    OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI  = 6'h0c, OP_ORI  = 6'h0d,
    OP_XORI  = 6'h0e, OP_LUI   = 6'h0f, OP_LB    = 6'h20, OP_LH   = 6'h21,
    OP_LW    = 6'h23, OP_LBU   = 6'h24, OP_LHU   = 6'h25, OP_SB   = 6'h28,
    OP_SH    = 6'h29, OP_SW    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA = 6'h03, FN_JR  = 6'h08,
    FN_JALR = 6'h09, FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24,
    FN_OR   = 6'h25, FN_XOR  = 6'h26, FN_NOR = 6'h27, FN_SLT = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } aluOp_e;

endpackage

/* common/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// First fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

// Physical address window of both memory ports
`define MIPS_PHYS_MASK 32'h1fff_ffff

`define MIPS_NUM_REGS 32

`endif
